/* build.f */
+incdir+source
source/axi_pkg.sv
source/soc_pkg.sv
source/axi_decoder.sv
source/axi_sram_bridge.sv
source/sram.sv
source/uart_peripheral.sv
source/soc_top.sv
verification/soc_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = soc_tb
FILELIST = build.f

SOURCES  = $(wildcard source/*.sv source/*.svh verification/*.sv)
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

/* verification/soc_tb.sv */
`include "soc_consts.svh"

module soc_tb;

   import axi_pkg::*;

   localparam int RGN_RAM  = 0;
   localparam int RGN_PERI = 1;
   localparam int RGN_NONE = 2;
   localparam logic [31:0] TXDATA_ADDR = `PERI_BASE;
   localparam logic [31:0] STATUS_ADDR = `PERI_BASE + 32'h8;
   // 120 ram, 12 unmapped, 16 under back-pressure, 4 uart
   localparam int N_TXN    = 152;
   localparam int N_FRAMES = 1;
   localparam int WATCHDOG_CYCLES = N_TXN * 20 + N_FRAMES * 10 * `UART_CLKS_PER_BIT * 2 + 100;

   logic clk, reset;
   axi_aw_t aw;
   axi_w_t w;
   axi_ar_t ar;
   logic aw_valid, w_valid, ar_valid, b_ready, r_ready;
   logic aw_ready, w_ready, ar_ready, b_valid, r_valid;
   axi_b_t b;
   axi_r_t r;
   logic uart_tx;

   logic [63:0] ram_model [int];
   axi_b_t exp_b [$];
   axi_r_t exp_r [$];
   bit started;
   int n_checks, n_value_err, n_other_err;

   soc_top u_dut (
      .clk      (clk),
      .reset    (reset),
      .aw       (aw),
      .w        (w),
      .ar       (ar),
      .aw_valid (aw_valid),
      .w_valid  (w_valid),
      .ar_valid (ar_valid),
      .b_ready  (b_ready),
      .r_ready  (r_ready),
      .aw_ready (aw_ready),
      .w_ready  (w_ready),
      .ar_ready (ar_ready),
      .b_valid  (b_valid),
      .r_valid  (r_valid),
      .b        (b),
      .r        (r),
      .uart_tx  (uart_tx)
   );

   always #5 clk = ~clk;

   function automatic int region_of(input logic [31:0] addr);
      if ((addr >> `RAM_SPAN_BITS) == (`RAM_BASE >> `RAM_SPAN_BITS))
         return RGN_RAM;
      if ((addr >> `PERI_SPAN_BITS) == (`PERI_BASE >> `PERI_SPAN_BITS))
         return RGN_PERI;
      return RGN_NONE;
   endfunction

   // merge by strobe into the model and give the expected write response
   function automatic axi_b_t apply_write(input logic [3:0] id, input logic [31:0] addr,
                                          input logic [63:0] data, input logic [7:0] strb);
      axi_b_t e;
      logic [63:0] word;
      int idx;
      e.id = id;
      e.resp = OKAY;
      idx = int'(addr[`RAM_INDEX_MSB:`RAM_INDEX_LSB]);
      if (region_of(addr) == RGN_RAM) begin
         word = ram_model.exists(idx) ? ram_model[idx] : '0;
         for (int i = 0; i < 8; i++)
            if (strb[i])
               word[i*8 +: 8] = data[i*8 +: 8];
         ram_model[idx] = word;
      end else if (region_of(addr) == RGN_NONE) begin
         e.resp = DECERR;
      end
      return e;
   endfunction

   // busy is the uart state the caller expects at the time of the read
   function automatic axi_r_t expect_read(input logic [3:0] id, input logic [31:0] addr,
                                          input logic busy);
      axi_r_t e;
      int idx;
      e.id = id;
      e.data = '0;
      e.resp = OKAY;
      e.last = 1'b1;
      idx = int'(addr[`RAM_INDEX_MSB:`RAM_INDEX_LSB]);
      if (region_of(addr) == RGN_RAM && ram_model.exists(idx))
         e.data = ram_model[idx];
      else if (region_of(addr) == RGN_PERI)
         e.data = {63'b0, busy && addr[3]};
      else if (region_of(addr) == RGN_NONE)
         e.resp = DECERR;
      return e;
   endfunction

   task automatic report_problem(input string msg);
      $display("Error at %0t: %s", $time, msg);
      n_other_err++;
   endtask

   task automatic compare_field(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
      n_checks++;
      if (actual !== expected) begin
         $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
         n_value_err++;
      end
   endtask

   // every response handshake against the expected queues
   always @(posedge clk) begin
      axi_b_t eb;
      axi_r_t er;
      if (reset || !started) begin
         if (b_valid || r_valid)
            report_problem("response valid before any request");
         if (uart_tx !== 1'b1)
            report_problem("uart_tx not idle high before any request");
      end
      if (!reset && b_valid && b_ready) begin
         if (exp_b.size() == 0) begin
            report_problem("write response with no write outstanding");
         end else begin
            eb = exp_b.pop_front();
            compare_field("b.id", 64'(eb.id), 64'(b.id));
            compare_field("b.resp", 64'(eb.resp), 64'(b.resp));
         end
      end
      if (!reset && r_valid && r_ready) begin
         if (exp_r.size() == 0) begin
            report_problem("read response with no read outstanding");
         end else begin
            er = exp_r.pop_front();
            compare_field("r.id", 64'(er.id), 64'(r.id));
            compare_field("r.data", er.data, r.data);
            compare_field("r.resp", 64'(er.resp), 64'(r.resp));
            compare_field("r.last", 64'(er.last), 64'(r.last));
         end
      end
   end

   task automatic start_write(input logic [3:0] id, input logic [31:0] addr,
                              input logic [63:0] data, input logic [7:0] strb);
      started = 1'b1;
      aw = '{id: id, addr: addr, len: 8'd0, size: 3'd3};
      w = '{data: data, strb: strb, last: 1'b1};
      aw_valid = 1'b1;
      w_valid = 1'b1;
      exp_b.push_back(apply_write(id, addr, data, strb));
   endtask

   task automatic accept_write();
      @(posedge clk);
      while (!(aw_valid && (aw_ready || w_ready)))
         @(posedge clk);
      if (aw_ready !== w_ready)
         report_problem("aw_ready and w_ready not raised together");
      #1;
      aw_valid = 1'b0;
      w_valid = 1'b0;
   endtask

   // b_ready stays low for stall cycles after b_valid shows up
   task automatic finish_write(input int stall);
      axi_b_t held;
      @(posedge clk);
      if (!b_valid) begin
         report_problem("b_valid not raised one cycle after the write handshake");
         while (!b_valid)
            @(posedge clk);
      end
      held = b;
      repeat (stall) begin
         @(posedge clk);
         if (!b_valid || b !== held)
            report_problem("write response dropped or changed while b_ready was low");
         if (aw_ready || w_ready)
            report_problem("new write accepted while a write response was pending");
      end
      #1 b_ready = 1'b1;
      @(posedge clk);
      #1 b_ready = 1'b0;
   endtask

   task automatic start_read(input logic [3:0] id, input logic [31:0] addr, input logic busy);
      started = 1'b1;
      ar = '{id: id, addr: addr, len: 8'd0, size: 3'd3};
      ar_valid = 1'b1;
      exp_r.push_back(expect_read(id, addr, busy));
   endtask

   task automatic accept_read();
      @(posedge clk);
      while (!(ar_valid && ar_ready))
         @(posedge clk);
      #1 ar_valid = 1'b0;
   endtask

   task automatic finish_read(input int stall);
      axi_r_t held;
      @(posedge clk);
      if (!r_valid) begin
         report_problem("r_valid not raised one cycle after the read handshake");
         while (!r_valid)
            @(posedge clk);
      end
      held = r;
      repeat (stall) begin
         @(posedge clk);
         if (!r_valid || r !== held)
            report_problem("read response dropped or changed while r_ready was low");
         if (ar_ready)
            report_problem("new read accepted while a read response was pending");
      end
      #1 r_ready = 1'b1;
      @(posedge clk);
      #1 r_ready = 1'b0;
   endtask

   task automatic single_write(input logic [3:0] id, input logic [31:0] addr,
                               input logic [63:0] data, input logic [7:0] strb);
      start_write(id, addr, data, strb);
      accept_write();
      finish_write(0);
   endtask

   task automatic single_read(input logic [3:0] id, input logic [31:0] addr, input logic busy);
      start_read(id, addr, busy);
      accept_read();
      finish_read(0);
   endtask

   // samples the middle of each bit after the start edge
   task automatic capture_frame(input logic [7:0] expected);
      @(negedge uart_tx);
      repeat (`UART_CLKS_PER_BIT / 2) @(posedge clk);
      if (uart_tx !== 1'b0)
         report_problem("uart start bit is not low at its center");
      for (int i = 0; i < 8; i++) begin
         repeat (`UART_CLKS_PER_BIT) @(posedge clk);
         if (uart_tx !== expected[i])
            report_problem($sformatf("uart data bit %0d wrong for byte %h", i, expected));
      end
      repeat (`UART_CLKS_PER_BIT) @(posedge clk);
      if (uart_tx !== 1'b1)
         report_problem("uart stop bit is not high at its center");
   endtask

   initial begin
      logic [31:0] pool [16];
      logic [31:0] unmapped [4];
      logic [7:0] tx_byte;
      void'($urandom(32'hd877869d));
      clk = 1'b0;
      reset = 1'b1;
      aw = '0;
      w = '0;
      ar = '0;
      aw_valid = 1'b0;
      w_valid = 1'b0;
      ar_valid = 1'b0;
      b_ready = 1'b0;
      r_ready = 1'b0;
      repeat (8) @(posedge clk);
      #1 reset = 1'b0;
      repeat (3) @(posedge clk);
      #1;

      // word 0 is also where 0x0 and 0x10000 alias
      pool[0] = `RAM_BASE;
      for (int i = 1; i < 16; i++)
         pool[i] = `RAM_BASE | ($urandom_range(4095, 0) << 3);
      for (int i = 0; i < 16; i++)
         single_write(4'($urandom), pool[i], {$urandom, $urandom}, 8'hff);
      for (int i = 0; i < 60; i++) begin
         if (i < 44)
            single_write(4'($urandom), pool[$urandom_range(15, 0)], {$urandom, $urandom},
                         8'($urandom));
         single_read(4'($urandom), pool[$urandom_range(15, 0)], 1'b0);
      end

      unmapped[0] = 32'h0001_0000;
      unmapped[1] = 32'h0000_0000;
      unmapped[2] = 32'h4000_0000 | (pool[3] & 32'h7ff8);
      unmapped[3] = 32'h1c01_0000 | (pool[5] & 32'h7ff8);
      for (int i = 0; i < 4; i++) begin
         single_write(4'($urandom), unmapped[i], {$urandom, $urandom}, 8'hff);
         single_read(4'($urandom), unmapped[i], 1'b0);
      end
      // aliased ram words must be untouched
      for (int i = 0; i < 4; i++)
         single_read(4'($urandom), `RAM_BASE | (unmapped[i] & 32'h7ff8), 1'b0);

      // next request waits on the channel while the response is held
      start_write(4'($urandom), pool[$urandom_range(15, 0)], {$urandom, $urandom}, 8'($urandom));
      accept_write();
      for (int i = 0; i < 7; i++) begin
         start_write(4'($urandom), pool[$urandom_range(15, 0)], {$urandom, $urandom},
                     8'($urandom));
         finish_write($urandom_range(5, 0));
         accept_write();
      end
      finish_write($urandom_range(5, 0));
      start_read(4'($urandom), pool[$urandom_range(15, 0)], 1'b0);
      accept_read();
      for (int i = 0; i < 7; i++) begin
         start_read(4'($urandom), pool[$urandom_range(15, 0)], 1'b0);
         finish_read($urandom_range(5, 0));
         accept_read();
      end
      finish_read($urandom_range(5, 0));

      tx_byte = 8'($urandom);
      fork
         capture_frame(tx_byte);
         begin
            single_write(4'($urandom), TXDATA_ADDR, {$urandom, 24'($urandom), tx_byte}, 8'h01);
            single_read(4'($urandom), STATUS_ADDR, 1'b1);
         end
      join
      repeat (`UART_CLKS_PER_BIT) @(posedge clk);
      #1;
      single_read(4'($urandom), STATUS_ADDR, 1'b0);
      single_read(4'($urandom), TXDATA_ADDR, 1'b0);

      repeat (2) @(posedge clk);
      if (exp_b.size() != 0 || exp_r.size() != 0)
         report_problem("responses still expected at the end of the test");
      $display("checks %0d, value errors %0d, other errors %0d",
               n_checks, n_value_err, n_other_err);
      if (n_value_err == 0 && n_other_err == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Error at %0t: run did not finish within %0d cycles", $time, WATCHDOG_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* source/soc_top.sv */
`include "soc_consts.svh"

module soc_top (
   input  logic             clk,
   input  logic             reset,
   input  axi_pkg::axi_aw_t aw,
   input  axi_pkg::axi_w_t  w,
   input  axi_pkg::axi_ar_t ar,
   input  logic             aw_valid, w_valid, ar_valid, b_ready, r_ready,
   output logic             aw_ready, w_ready, ar_ready, b_valid, r_valid,
   output axi_pkg::axi_b_t  b,
   output axi_pkg::axi_r_t  r,
   output logic             uart_tx
);

   import axi_pkg::*;
   import soc_pkg::*;

   axi_aw_t ram_aw, peri_aw;
   axi_w_t  ram_w, peri_w;
   axi_ar_t ram_ar, peri_ar;
   axi_b_t  ram_b, peri_b;
   axi_r_t  ram_r, peri_r;
   logic ram_aw_valid, ram_w_valid, ram_ar_valid, ram_b_ready, ram_r_ready;
   logic ram_aw_ready, ram_w_ready, ram_ar_ready, ram_b_valid, ram_r_valid;
   logic peri_aw_valid, peri_w_valid, peri_ar_valid, peri_b_ready, peri_r_ready;
   logic peri_aw_ready, peri_w_ready, peri_ar_ready, peri_b_valid, peri_r_valid;
   mem_req_t ram_req, peri_req;
   logic [`DATA_WIDTH-1:0] ram_rdata, peri_rdata;

   axi_decoder u_decoder (
      .clk           (clk),
      .reset         (reset),
      .aw            (aw),
      .w             (w),
      .ar            (ar),
      .aw_valid      (aw_valid),
      .w_valid       (w_valid),
      .ar_valid      (ar_valid),
      .b_ready       (b_ready),
      .r_ready       (r_ready),
      .aw_ready      (aw_ready),
      .w_ready       (w_ready),
      .ar_ready      (ar_ready),
      .b_valid       (b_valid),
      .r_valid       (r_valid),
      .b             (b),
      .r             (r),
      .ram_aw        (ram_aw),
      .ram_w         (ram_w),
      .ram_ar        (ram_ar),
      .ram_aw_valid  (ram_aw_valid),
      .ram_w_valid   (ram_w_valid),
      .ram_ar_valid  (ram_ar_valid),
      .ram_b_ready   (ram_b_ready),
      .ram_r_ready   (ram_r_ready),
      .ram_aw_ready  (ram_aw_ready),
      .ram_w_ready   (ram_w_ready),
      .ram_ar_ready  (ram_ar_ready),
      .ram_b_valid   (ram_b_valid),
      .ram_r_valid   (ram_r_valid),
      .ram_b         (ram_b),
      .ram_r         (ram_r),
      .peri_aw       (peri_aw),
      .peri_w        (peri_w),
      .peri_ar       (peri_ar),
      .peri_aw_valid (peri_aw_valid),
      .peri_w_valid  (peri_w_valid),
      .peri_ar_valid (peri_ar_valid),
      .peri_b_ready  (peri_b_ready),
      .peri_r_ready  (peri_r_ready),
      .peri_aw_ready (peri_aw_ready),
      .peri_w_ready  (peri_w_ready),
      .peri_ar_ready (peri_ar_ready),
      .peri_b_valid  (peri_b_valid),
      .peri_r_valid  (peri_r_valid),
      .peri_b        (peri_b),
      .peri_r        (peri_r)
   );

   axi_sram_bridge u_ram_bridge (
      .clk      (clk),
      .reset    (reset),
      .aw       (ram_aw),
      .w        (ram_w),
      .ar       (ram_ar),
      .aw_valid (ram_aw_valid),
      .w_valid  (ram_w_valid),
      .ar_valid (ram_ar_valid),
      .b_ready  (ram_b_ready),
      .r_ready  (ram_r_ready),
      .aw_ready (ram_aw_ready),
      .w_ready  (ram_w_ready),
      .ar_ready (ram_ar_ready),
      .b_valid  (ram_b_valid),
      .r_valid  (ram_r_valid),
      .b        (ram_b),
      .r        (ram_r),
      .req      (ram_req),
      .rdata    (ram_rdata)
   );

   axi_sram_bridge u_peri_bridge (
      .clk      (clk),
      .reset    (reset),
      .aw       (peri_aw),
      .w        (peri_w),
      .ar       (peri_ar),
      .aw_valid (peri_aw_valid),
      .w_valid  (peri_w_valid),
      .ar_valid (peri_ar_valid),
      .b_ready  (peri_b_ready),
      .r_ready  (peri_r_ready),
      .aw_ready (peri_aw_ready),
      .w_ready  (peri_w_ready),
      .ar_ready (peri_ar_ready),
      .b_valid  (peri_b_valid),
      .r_valid  (peri_r_valid),
      .b        (peri_b),
      .r        (peri_r),
      .req      (peri_req),
      .rdata    (peri_rdata)
   );

   sram u_ram (
      .clk   (clk),
      .req   (ram_req),
      .rdata (ram_rdata)
   );

   uart_peripheral u_peri (
      .clk     (clk),
      .reset   (reset),
      .req     (peri_req),
      .rdata   (peri_rdata),
      .uart_tx (uart_tx)
   );

endmodule

/* source/uart_peripheral.sv */
`include "soc_consts.svh"

module uart_peripheral (
   input  logic                   clk,
   input  logic                   reset,
   input  soc_pkg::mem_req_t      req,
   output logic [`DATA_WIDTH-1:0] rdata,
   output logic                   uart_tx
);

   import soc_pkg::*;

   localparam int WORD_LSB = $clog2(`STRB_WIDTH);
   localparam int BAUD_W   = $clog2(`UART_CLKS_PER_BIT);

   typedef enum logic [1:0] {
      IDLE,
      START,
      DATA,
      STOP
   } tx_state_t;

   tx_state_t state;
   logic [BAUD_W-1:0] baud_cnt;
   logic [2:0] bit_cnt;
   logic [7:0] shift;
   logic busy, baud_tick, load;
   peri_reg_t wreg, rreg;

   assign wreg      = peri_reg_t'(req.waddr[WORD_LSB]);
   assign rreg      = peri_reg_t'(req.raddr[WORD_LSB]);
   assign busy      = state != IDLE;
   assign baud_tick = baud_cnt == BAUD_W'(`UART_CLKS_PER_BIT - 1);
   // writes during a frame are dropped
   assign load      = req.wen[0] && wreg == REG_TXDATA && !busy;

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         baud_cnt <= (state == IDLE || baud_tick) ? '0 : baud_cnt + 1'b1;
         case (state)
            IDLE: begin
               if (load)
                  state <= START;
            end
            START: begin
               if (baud_tick)
                  state <= DATA;
            end
            DATA: begin
               if (baud_tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 3'd7)
                     state <= STOP;
               end
            end
            STOP: begin
               if (baud_tick)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // lsb first
   always_ff @(posedge clk) begin
      if (load)
         shift <= req.wdata[7:0];
      else if (state == DATA && baud_tick)
         shift <= shift >> 1;
   end

   always_comb begin
      case (state)
         START:   uart_tx = 1'b0;
         DATA:    uart_tx = shift[0];
         default: uart_tx = 1'b1;
      endcase
   end

   // txdata reads back as zero
   always_ff @(posedge clk) begin
      if (req.ren)
         rdata <= rreg == REG_STATUS ? {{(`DATA_WIDTH-1){1'b0}}, busy} : '0;
   end

endmodule

/* source/sram.sv */
`include "soc_consts.svh"

module sram (
   input  logic                   clk,
   input  soc_pkg::mem_req_t      req,
   output logic [`DATA_WIDTH-1:0] rdata
);

   localparam int IDX_W = `RAM_INDEX_MSB - `RAM_INDEX_LSB + 1;

   logic [`DATA_WIDTH-1:0] mem [0:`RAM_DEPTH-1];
   logic [IDX_W-1:0] widx, ridx;

   assign widx = req.waddr[`RAM_INDEX_MSB:`RAM_INDEX_LSB];
   assign ridx = req.raddr[`RAM_INDEX_MSB:`RAM_INDEX_LSB];

   always_ff @(posedge clk) begin
      for (int i = 0; i < `STRB_WIDTH; i++) begin
         if (req.wen[i])
            mem[widx][i*8 +: 8] <= req.wdata[i*8 +: 8];
      end
      if (req.ren)
         rdata <= mem[ridx];
   end

endmodule

/* source/axi_sram_bridge.sv */
`include "soc_consts.svh"

module axi_sram_bridge (
   input  logic                   clk,
   input  logic                   reset,
   input  axi_pkg::axi_aw_t       aw,
   input  axi_pkg::axi_w_t        w,
   input  axi_pkg::axi_ar_t       ar,
   input  logic                   aw_valid, w_valid, ar_valid, b_ready, r_ready,
   output logic                   aw_ready, w_ready, ar_ready, b_valid, r_valid,
   output axi_pkg::axi_b_t        b,
   output axi_pkg::axi_r_t        r,
   output soc_pkg::mem_req_t      req,
   input  logic [`DATA_WIDTH-1:0] rdata
);

   import axi_pkg::*;
   import soc_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      WRESP,
      RRESP
   } state_t;

   state_t state;
   logic wr_go, rd_go;
   logic rd_fresh;
   logic [`ID_WIDTH-1:0] id_q;
   logic [`DATA_WIDTH-1:0] rdata_q;

   // writes win when both sides arrive together
   assign wr_go = state == IDLE && aw_valid && w_valid;
   assign rd_go = state == IDLE && ar_valid && !(aw_valid && w_valid);

   assign aw_ready = wr_go;
   assign w_ready  = wr_go;
   assign ar_ready = rd_go;

   always_comb begin
      req.ren   = rd_go;
      req.raddr = ar.addr;
      req.waddr = aw.addr;
      req.wdata = w.data;
      req.wen   = wr_go ? w.strb : '0;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         rd_fresh <= 1'b0;
      end else begin
         rd_fresh <= rd_go;
         case (state)
            IDLE: begin
               if (wr_go)
                  state <= WRESP;
               else if (rd_go)
                  state <= RRESP;
            end
            WRESP: begin
               if (b_ready)
                  state <= IDLE;
            end
            RRESP: begin
               if (r_ready)
                  state <= IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // memory data is live in the first response cycle, held after that
   always_ff @(posedge clk) begin
      if (wr_go)
         id_q <= aw.id;
      else if (rd_go)
         id_q <= ar.id;
      if (rd_fresh)
         rdata_q <= rdata;
   end

   assign b_valid = state == WRESP;
   assign b       = '{id: id_q, resp: OKAY};
   assign r_valid = state == RRESP;
   assign r       = '{id: id_q, data: rd_fresh ? rdata : rdata_q, resp: OKAY, last: 1'b1};

   a_single_beat: assert property (@(posedge clk) disable iff (reset)
      (aw_valid |-> aw.len == 8'd0) and (ar_valid |-> ar.len == 8'd0));

   a_b_hold: assert property (@(posedge clk) disable iff (reset)
      b_valid && !b_ready |=> b_valid && $stable(b));

endmodule

/* source/axi_decoder.sv */
`include "soc_consts.svh"

module axi_decoder (
   input  logic             clk,
   input  logic             reset,
   // master side
   input  axi_pkg::axi_aw_t aw,
   input  axi_pkg::axi_w_t  w,
   input  axi_pkg::axi_ar_t ar,
   input  logic             aw_valid, w_valid, ar_valid, b_ready, r_ready,
   output logic             aw_ready, w_ready, ar_ready, b_valid, r_valid,
   output axi_pkg::axi_b_t  b,
   output axi_pkg::axi_r_t  r,
   // ram slave
   output axi_pkg::axi_aw_t ram_aw,
   output axi_pkg::axi_w_t  ram_w,
   output axi_pkg::axi_ar_t ram_ar,
   output logic             ram_aw_valid, ram_w_valid, ram_ar_valid, ram_b_ready, ram_r_ready,
   input  logic             ram_aw_ready, ram_w_ready, ram_ar_ready, ram_b_valid, ram_r_valid,
   input  axi_pkg::axi_b_t  ram_b,
   input  axi_pkg::axi_r_t  ram_r,
   // peripheral slave
   output axi_pkg::axi_aw_t peri_aw,
   output axi_pkg::axi_w_t  peri_w,
   output axi_pkg::axi_ar_t peri_ar,
   output logic             peri_aw_valid, peri_w_valid, peri_ar_valid, peri_b_ready,
   output logic             peri_r_ready,
   input  logic             peri_aw_ready, peri_w_ready, peri_ar_ready, peri_b_valid,
   input  logic             peri_r_valid,
   input  axi_pkg::axi_b_t  peri_b,
   input  axi_pkg::axi_r_t  peri_r
);

   import axi_pkg::*;
   import soc_pkg::*;

   localparam logic [`ADDR_WIDTH-1:0] RAM_BASE_ADDR  = `RAM_BASE;
   localparam logic [`ADDR_WIDTH-1:0] PERI_BASE_ADDR = `PERI_BASE;

   slave_sel_t aw_sel, ar_sel, wr_sel, rd_sel;
   logic wr_busy, rd_busy;
   logic err_wr_go, err_rd_go;
   logic err_b_valid, err_r_valid;
   logic [`ID_WIDTH-1:0] err_bid, err_rid;

   function automatic slave_sel_t decode(input logic [`ADDR_WIDTH-1:0] addr);
      if (addr[`ADDR_WIDTH-1:`RAM_SPAN_BITS] == RAM_BASE_ADDR[`ADDR_WIDTH-1:`RAM_SPAN_BITS])
         return SEL_RAM;
      if (addr[`ADDR_WIDTH-1:`PERI_SPAN_BITS] == PERI_BASE_ADDR[`ADDR_WIDTH-1:`PERI_SPAN_BITS])
         return SEL_PERI;
      return SEL_NONE;
   endfunction

   assign aw_sel = decode(aw.addr);
   assign ar_sel = decode(ar.addr);

   // payloads go to both slaves, only valid is steered
   assign ram_aw  = aw;
   assign ram_w   = w;
   assign ram_ar  = ar;
   assign peri_aw = aw;
   assign peri_w  = w;
   assign peri_ar = ar;

   assign ram_aw_valid  = aw_valid && !wr_busy && aw_sel == SEL_RAM;
   assign ram_w_valid   = w_valid && !wr_busy && aw_sel == SEL_RAM;
   assign peri_aw_valid = aw_valid && !wr_busy && aw_sel == SEL_PERI;
   assign peri_w_valid  = w_valid && !wr_busy && aw_sel == SEL_PERI;
   assign ram_ar_valid  = ar_valid && !rd_busy && ar_sel == SEL_RAM;
   assign peri_ar_valid = ar_valid && !rd_busy && ar_sel == SEL_PERI;

   // unmapped requests are taken here
   assign err_wr_go = aw_valid && w_valid && !wr_busy && aw_sel == SEL_NONE;
   assign err_rd_go = ar_valid && !rd_busy && ar_sel == SEL_NONE;

   // a bridge only raises ready against its own valid
   assign aw_ready = ram_aw_ready || peri_aw_ready || err_wr_go;
   assign w_ready  = ram_w_ready || peri_w_ready || err_wr_go;
   assign ar_ready = ram_ar_ready || peri_ar_ready || err_rd_go;

   assign b_valid = wr_sel == SEL_RAM  ? ram_b_valid :
                    wr_sel == SEL_PERI ? peri_b_valid : err_b_valid;
   assign b       = wr_sel == SEL_RAM  ? ram_b :
                    wr_sel == SEL_PERI ? peri_b : '{id: err_bid, resp: DECERR};
   assign r_valid = rd_sel == SEL_RAM  ? ram_r_valid :
                    rd_sel == SEL_PERI ? peri_r_valid : err_r_valid;
   assign r       = rd_sel == SEL_RAM  ? ram_r :
                    rd_sel == SEL_PERI ? peri_r :
                    '{id: err_rid, data: '0, resp: DECERR, last: 1'b1};

   assign ram_b_ready  = b_ready && wr_sel == SEL_RAM;
   assign peri_b_ready = b_ready && wr_sel == SEL_PERI;
   assign ram_r_ready  = r_ready && rd_sel == SEL_RAM;
   assign peri_r_ready = r_ready && rd_sel == SEL_PERI;

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_busy     <= 1'b0;
         wr_sel      <= SEL_NONE;
         err_b_valid <= 1'b0;
      end else if (aw_valid && aw_ready) begin
         wr_busy     <= 1'b1;
         wr_sel      <= aw_sel;
         err_b_valid <= aw_sel == SEL_NONE;
      end else if (b_valid && b_ready) begin
         wr_busy     <= 1'b0;
         err_b_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_busy     <= 1'b0;
         rd_sel      <= SEL_NONE;
         err_r_valid <= 1'b0;
      end else if (ar_valid && ar_ready) begin
         rd_busy     <= 1'b1;
         rd_sel      <= ar_sel;
         err_r_valid <= ar_sel == SEL_NONE;
      end else if (r_valid && r_ready) begin
         rd_busy     <= 1'b0;
         err_r_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (err_wr_go)
         err_bid <= aw.id;
      if (err_rd_go)
         err_rid <= ar.id;
   end

   a_one_r_source: assert property (@(posedge clk) disable iff (reset)
      $onehot0({ram_r_valid, peri_r_valid, err_r_valid}));

endmodule

/* source/soc_pkg.sv */
`include "soc_consts.svh"

package soc_pkg;

   typedef enum logic [1:0] {
      SEL_RAM,
      SEL_PERI,
      SEL_NONE
   } slave_sel_t;

   // memory side of a bridge
   typedef struct packed {
      logic                   ren;
      logic [`ADDR_WIDTH-1:0] raddr;
      logic [`ADDR_WIDTH-1:0] waddr;
      logic [`DATA_WIDTH-1:0] wdata;
      logic [`STRB_WIDTH-1:0] wen;
   } mem_req_t;

   // word offset inside the peripheral window
   typedef enum logic {
      REG_TXDATA = 1'b0,
      REG_STATUS = 1'b1
   } peri_reg_t;

endpackage

/* source/axi_pkg.sv */
`include "soc_consts.svh"

package axi_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      DECERR = 2'b11
   } axi_resp_t;

   // single beat only, so no burst type
   typedef struct packed {
      logic [`ID_WIDTH-1:0]   id;
      logic [`ADDR_WIDTH-1:0] addr;
      logic [7:0]             len;
      logic [2:0]             size;
   } axi_aw_t;

   // read address has the same layout
   typedef axi_aw_t axi_ar_t;

   typedef struct packed {
      logic [`DATA_WIDTH-1:0] data;
      logic [`STRB_WIDTH-1:0] strb;
      logic                   last;
   } axi_w_t;

   typedef struct packed {
      logic [`ID_WIDTH-1:0] id;
      axi_resp_t            resp;
   } axi_b_t;

   typedef struct packed {
      logic [`ID_WIDTH-1:0]   id;
      logic [`DATA_WIDTH-1:0] data;
      axi_resp_t              resp;
      logic                   last;
   } axi_r_t;

endpackage

/* source/soc_consts.svh */
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// bus widths
`define ADDR_WIDTH        32
`define DATA_WIDTH        64
`define STRB_WIDTH        8
`define ID_WIDTH          4

// address map in 64 KB regions
`define RAM_BASE          32'h1c00_0000
`define RAM_SPAN_BITS     16
`define PERI_BASE         32'h0002_0000
`define PERI_SPAN_BITS    16

// 4096 words of 64 bits indexed by address bits 14:3
`define RAM_DEPTH         4096
`define RAM_INDEX_LSB     3
`define RAM_INDEX_MSB     14

`define UART_CLKS_PER_BIT 16

`endif
